// File: hdl/msx_pkg.sv
/*
 * MSX slot subsystem package
 * Widths, configuration addresses, layout entry field positions and the
 * enumerated types shared by the slot logic and its testbench
 */
`default_nettype none

package msx_pkg;

    // External memory is 4 MB of bytes
    localparam int MEM_AW = 22;

    // Block bases are counted in 16 KB units
    localparam int BASE_W = 8;

    // Configuration port widths
    localparam int CFG_AW = 7;
    localparam int CFG_DW = 16;

    // Addresses 0 to 63 hit the layout table and 64 holds the expander mask
    localparam logic [CFG_AW-1:0] CFG_EXPANDER = 7'd64;

    // A layout entry is type, read-only flag, cartridge number and base
    localparam int ENT_TYPE_LSB = 0;
    localparam int ENT_RO_BIT   = 2;
    localparam int ENT_CART_BIT = 3;
    localparam int ENT_BASE_LSB = 4;
    localparam int ENT_W        = ENT_BASE_LSB + BASE_W;

    // Kind of block that a 16 KB page of a subslot shows
    typedef enum logic [1:0] {
        BLK_NONE   = 2'd0,
        BLK_RAM    = 2'd1,
        BLK_ROM    = 2'd2,
        BLK_ASCII8 = 2'd3
    } block_type_e;

    // States of the CPU access FSM in the top level
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_MEM     = 2'd1,
        ST_MEM_REL = 2'd2,
        ST_DONE    = 2'd3
    } acc_state_e;

endpackage

`default_nettype wire

// File: hdl/subslot_reg.sv
/*
 * Secondary slot registers
 * Holds the expander mask and one subslot register per primary slot,
 * answers CPU accesses to FFFF of expanded slots with the inverted value
 */
`timescale 1ns/10ps
`default_nettype none

module subslot_reg (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cfg_we,
    input  wire  [msx_pkg::CFG_AW-1:0] cfg_addr,
    input  wire  [msx_pkg::CFG_DW-1:0] cfg_data,
    input  wire                        acc_en,
    input  wire                        cpu_we,
    input  wire  [15:0]                cpu_addr,
    input  wire  [7:0]                 cpu_wdata,
    input  wire  [1:0]                 page_slot,
    output logic [1:0]                 sub_sel,
    output logic                       sub_hit,
    output logic [7:0]                 sub_rdata
);
    import msx_pkg::*;

    logic [3:0] expander;
    logic [7:0] sub_reg [4];
    logic [1:0] page;
    logic [7:0] cur_reg;
    logic       cur_exp;

    // Everything is looked up through the primary slot of the addressed page
    assign page    = cpu_addr[15:14];
    assign cur_reg = sub_reg[page_slot];
    assign cur_exp = expander[page_slot];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expander <= '0;
            for (int i = 0; i < 4; i++) begin
                sub_reg[i] <= '0;
            end
        end else begin
            // Only the low nibble carries the mask, one bit per primary slot
            if (cfg_we && cfg_addr == CFG_EXPANDER) begin
                expander <= cfg_data[3:0];
            end
            // The register is loaded on the same edge that accepts the access
            if (acc_en && cpu_we && sub_hit) begin
                sub_reg[page_slot] <= cpu_wdata;
            end
        end
    end

    // FFFF sits in page 3, so page_slot already points at the right slot
    assign sub_hit   = (cpu_addr == 16'hFFFF) && cur_exp;
    assign sub_rdata = ~cur_reg;

    // A plain slot always behaves as subslot 0
    assign sub_sel = cur_exp ? cur_reg[{page, 1'b0} +: 2] : 2'b00;

endmodule

`default_nettype wire

// File: hdl/slot_layout_map.sv
/*
 * Slot layout table
 * 64 entries, one per primary slot, subslot and 16 KB page, each giving
 * the block type, read-only flag, cartridge number and memory base
 */
`timescale 1ns/10ps
`default_nettype none

module slot_layout_map (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cfg_we,
    input  wire  [msx_pkg::CFG_AW-1:0] cfg_addr,
    input  wire  [msx_pkg::CFG_DW-1:0] cfg_data,
    input  wire  [1:0]                 page_slot,
    input  wire  [1:0]                 sub_sel,
    input  wire  [1:0]                 page,
    output msx_pkg::block_type_e       blk_type,
    output logic                       blk_ro,
    output logic                       blk_cart,
    output logic [msx_pkg::BASE_W-1:0] blk_base
);
    import msx_pkg::*;

    logic [ENT_W-1:0] layout_q [64];
    logic [5:0]       rd_idx;
    logic [ENT_W-1:0] entry;
    logic             cfg_hit;

    // The expander address and everything above it are not table entries
    assign cfg_hit = cfg_we && (cfg_addr < CFG_EXPANDER);

    // Entries clear to zero, which decodes as BLK_NONE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                layout_q[i] <= '0;
            end
        end else if (cfg_hit) begin
            layout_q[cfg_addr[5:0]] <= cfg_data[ENT_W-1:0];
        end
    end

    // Index is slot times 16 plus subslot times 4 plus page
    assign rd_idx = {page_slot, sub_sel, page};
    assign entry  = layout_q[rd_idx];

    // Split the entry into its fields
    assign blk_type = block_type_e'(entry[ENT_TYPE_LSB +: 2]);
    assign blk_ro   = entry[ENT_RO_BIT];
    assign blk_cart = entry[ENT_CART_BIT];
    assign blk_base = entry[ENT_BASE_LSB +: BASE_W];

endmodule

`default_nettype wire

// File: hdl/ascii8_mapper.sv
/*
 * ASCII8 cartridge mapper
 * Four 8 KB bank registers for each of two cartridges, written through
 * 6000-7FFF, and the mapped ROM offset for the 4000-BFFF window
 */
`timescale 1ns/10ps
`default_nettype none

module ascii8_mapper (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        acc_en,
    input  wire                        cpu_we,
    input  wire  [15:0]                cpu_addr,
    input  wire  [7:0]                 cpu_wdata,
    input  msx_pkg::block_type_e       blk_type,
    input  wire                        blk_cart,
    output logic                       bank_wr,
    output logic [msx_pkg::MEM_AW-1:0] map_offset
);
    import msx_pkg::*;

    logic [7:0] bank_q [2][4];
    logic [1:0] window;
    logic [7:0] win_bank;

    // Any write to 6000-7FFF of an ASCII8 block goes to a bank register
    // and never reaches the ROM behind it
    assign bank_wr = cpu_we && (blk_type == BLK_ASCII8) && (cpu_addr[15:13] == 3'b011);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < 2; c++) begin
                for (int b = 0; b < 4; b++) begin
                    bank_q[c][b] <= '0;
                end
            end
        end else if (acc_en && bank_wr) begin
            // 6000, 6800, 7000 and 7800 select banks 0 to 3
            bank_q[blk_cart][cpu_addr[12:11]] <= cpu_wdata;
        end
    end

    // Windows 4000, 6000, 8000 and A000 map to banks 0 to 3
    // The two bit subtraction wraps 8000 and A000 around to 2 and 3
    assign window = cpu_addr[14:13] - 2'd2;

    assign win_bank = bank_q[blk_cart][window];

    // Offset into the cartridge image is bank times 8 KB plus the offset
    // inside the window, and it only means something for 4000-BFFF
    assign map_offset = {{(MEM_AW - 21){1'b0}}, win_bank, cpu_addr[12:0]};

endmodule

`default_nettype wire

// File: hdl/msx_slots.sv
/*
 * MSX slot subsystem top level
 * Accepts CPU accesses over a four-phase handshake, resolves primary slot,
 * subslot and layout entry into an external memory address and forwards
 * the access to memory over a second four-phase handshake
 */
`timescale 1ns/10ps
`default_nettype none

module msx_slots (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cfg_we,
    input  wire  [msx_pkg::CFG_AW-1:0] cfg_addr,
    input  wire  [msx_pkg::CFG_DW-1:0] cfg_data,
    input  wire  [7:0]                 slot_sel,
    input  wire                        cpu_req,
    input  wire                        cpu_we,
    input  wire  [15:0]                cpu_addr,
    input  wire  [7:0]                 cpu_wdata,
    output logic                       cpu_ack,
    output logic [7:0]                 cpu_rdata,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [msx_pkg::MEM_AW-1:0] mem_addr,
    output logic [7:0]                 mem_wdata,
    input  wire                        mem_ack,
    input  wire  [7:0]                 mem_rdata
);
    import msx_pkg::*;

    acc_state_e        state;
    logic [1:0]        page;
    logic [1:0]        page_slot;
    logic [1:0]        sub_sel;
    logic              sub_hit;
    logic [7:0]        sub_rdata;
    block_type_e       blk_type;
    logic              blk_ro;
    logic              blk_cart;
    logic [BASE_W-1:0] blk_base;
    logic              bank_wr;
    logic [MEM_AW-1:0] map_offset;
    logic [MEM_AW-1:0] base_addr;
    logic [MEM_AW-1:0] mem_addr_nx;
    logic              acc_en;
    logic              wr_blocked;
    logic              internal;
    logic [7:0]        rdata_q;

    // Port A8 holds two bits of primary slot per page
    assign page      = cpu_addr[15:14];
    assign page_slot = slot_sel[{page, 1'b0} +: 2];

    // An access is taken on the edge where the FSM idles with a request up
    assign acc_en = (state == ST_IDLE) && cpu_req;

    subslot_reg u_subslot (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .acc_en    (acc_en),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .page_slot (page_slot),
        .sub_sel   (sub_sel),
        .sub_hit   (sub_hit),
        .sub_rdata (sub_rdata)
    );

    slot_layout_map u_layout (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .page_slot (page_slot),
        .sub_sel   (sub_sel),
        .page      (page),
        .blk_type  (blk_type),
        .blk_ro    (blk_ro),
        .blk_cart  (blk_cart),
        .blk_base  (blk_base)
    );

    ascii8_mapper u_ascii8 (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_en     (acc_en),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .blk_type   (blk_type),
        .blk_cart   (blk_cart),
        .bank_wr    (bank_wr),
        .map_offset (map_offset)
    );

    // Writes into ROM images or write protected RAM are silently dropped
    assign wr_blocked = cpu_we && ((blk_type == BLK_ROM) || (blk_type == BLK_ASCII8) ||
                                   ((blk_type == BLK_RAM) && blk_ro));

    // These accesses finish inside the subsystem without touching memory
    assign internal = sub_hit || bank_wr || wr_blocked || (blk_type == BLK_NONE);

    // Block base in 16 KB units lands on address bits 21 to 14
    assign base_addr = {blk_base, 14'b0};

    always_comb begin
        if (blk_type == BLK_ASCII8) begin
            mem_addr_nx = base_addr + map_offset;
        end else begin
            mem_addr_nx = base_addr + {{(MEM_AW - 14){1'b0}}, cpu_addr[13:0]};
        end
    end

    // Memory side fields are latched at acceptance and stay put through
    // the whole memory handshake
    always_ff @(posedge clk) begin
        if (acc_en) begin
            mem_addr  <= mem_addr_nx;
            mem_we    <= cpu_we;
            mem_wdata <= cpu_wdata;
        end
        if ((state == ST_MEM) && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            cpu_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cpu_req && internal) begin
                        cpu_ack <= 1'b1;
                        state   <= ST_DONE;
                    end else if (cpu_req) begin
                        mem_req <= 1'b1;
                        state   <= ST_MEM;
                    end
                end
                // Wait for memory to answer, then release the request
                ST_MEM: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_MEM_REL;
                    end
                end
                // The memory handshake closes before the CPU sees its ack
                ST_MEM_REL: begin
                    if (!mem_ack) begin
                        cpu_ack <= 1'b1;
                        state   <= ST_DONE;
                    end
                end
                // Hold ack until the CPU withdraws its request
                ST_DONE: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Subslot register wins over the page contents at FFFF
    // and empty pages float high like an open bus
    assign cpu_rdata = sub_hit ? sub_rdata :
                       (blk_type == BLK_NONE) ? 8'hFF : rdata_q;

endmodule

`default_nettype wire

// File: verif/tb_memory.sv
/*
 * Behavioral external memory
 * 4 MB of bytes that read as an address pattern until written,
 * answering the four-phase request after 0 to 3 random wait cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_memory (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        mem_req,
    input  wire                        mem_we,
    input  wire  [msx_pkg::MEM_AW-1:0] mem_addr,
    input  wire  [7:0]                 mem_wdata,
    output logic                       mem_ack,
    output logic [7:0]                 mem_rdata
);
    import msx_pkg::*;

    // Only written bytes are stored, the rest still hold the preload
    logic [7:0] bytes [int];
    int         seed = 96390;
    int         delay = 0;

    // Every bit of the address changes the byte, so a wrong high bit shows up
    function automatic logic [7:0] preload_byte(input logic [MEM_AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'hA5;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ack   <= 1'b0;
            mem_rdata <= 8'h00;
        end else if (mem_ack) begin
            // Release once the requester has dropped its request
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req) begin
            if (delay > 0) begin
                delay = delay - 1;
            end else begin
                if (mem_we) begin
                    bytes[int'(mem_addr)] = mem_wdata;
                end
                if (bytes.exists(int'(mem_addr))) begin
                    mem_rdata <= bytes[int'(mem_addr)];
                end else begin
                    mem_rdata <= preload_byte(mem_addr);
                end
                mem_ack <= 1'b1;
                // Wait time of the next request
                delay = $random(seed) & 3;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/msx_slots_tb.sv
/*
 * Testbench for the MSX slot subsystem
 * Loads a slot layout, runs directed tests for reset, RAM, subslots,
 * ASCII8 banking and write protection, then random accesses, and checks
 * every access against a reference model kept in shadow state
 */
`timescale 1ns/10ps
`default_nettype none

module msx_slots_tb;
    import msx_pkg::*;

    // About 550 accesses of at most a dozen cycles plus setup, with margin
    localparam int MAX_CYCLES = 20000;
    localparam int N_RANDOM   = 500;

    // What one access should produce, queued before it starts
    typedef struct packed {
        logic              we;
        logic [7:0]        data;
        logic [7:0]        wdata;
        logic              to_mem;
        logic [MEM_AW-1:0] maddr;
        logic [31:0]       starts;
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              cfg_we;
    logic [CFG_AW-1:0] cfg_addr;
    logic [CFG_DW-1:0] cfg_data;
    logic [7:0]        slot_sel;
    logic              cpu_req;
    logic              cpu_we;
    logic [15:0]       cpu_addr;
    logic [7:0]        cpu_wdata;
    logic              cpu_ack;
    logic [7:0]        cpu_rdata;
    logic              mem_req;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [7:0]        mem_wdata;
    logic              mem_ack;
    logic [7:0]        mem_rdata;

    // Shadow copies of everything the slot rules depend on
    logic [ENT_W-1:0]  lay_sh [64];
    logic [3:0]        mask_sh;
    logic [7:0]        sub_sh [4];
    logic [7:0]        bank_sh [2][4];
    logic [7:0]        mem_sh [int];
    expect_t           exp_q [$];

    int seed;
    int cycles;
    int mem_starts;
    int checks;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    msx_slots uut (.*);

    tb_memory mem (.*);

    always #10 clk = ~clk;

    // Same pattern that the memory model reads for unwritten bytes
    function automatic logic [7:0] preload_byte(input logic [MEM_AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'hA5;
    endfunction

    function automatic logic [1:0] slot_of(input logic [15:0] addr);
        return slot_sel[{addr[15:14], 1'b0} +: 2];
    endfunction

    // Layout entry seen at this address through slot, subslot and page
    function automatic logic [ENT_W-1:0] entry_of(input logic [15:0] addr);
        logic [1:0] ps;
        logic [1:0] ss;
        ps = slot_of(addr);
        ss = mask_sh[ps] ? sub_sh[ps][{addr[15:14], 1'b0} +: 2] : 2'b00;
        return lay_sh[{ps, ss, addr[15:14]}];
    endfunction

    function automatic logic sub_access(input logic [15:0] addr);
        return (addr == 16'hFFFF) && mask_sh[slot_of(addr)];
    endfunction

    function automatic logic [MEM_AW-1:0] map_addr(input logic [15:0] addr);
        logic [ENT_W-1:0]  e;
        logic [MEM_AW-1:0] base;
        logic [1:0]        win;
        e    = entry_of(addr);
        base = {e[ENT_BASE_LSB +: BASE_W], 14'b0};
        // Window 4000 uses bank 0 up to A000 using bank 3
        win  = addr[14:13] - 2'd2;
        if (e[ENT_TYPE_LSB +: 2] == BLK_ASCII8) begin
            return base + {1'b0, bank_sh[e[ENT_CART_BIT]][win], addr[12:0]};
        end
        return base + {8'b0, addr[13:0]};
    endfunction

    function automatic logic reaches_memory(input logic we, input logic [15:0] addr);
        logic [ENT_W-1:0] e;
        e = entry_of(addr);
        if (sub_access(addr) || e[ENT_TYPE_LSB +: 2] == BLK_NONE) begin
            return 1'b0;
        end
        if (!we) begin
            return 1'b1;
        end
        return (e[ENT_TYPE_LSB +: 2] == BLK_RAM) && !e[ENT_RO_BIT];
    endfunction

    // Expected read data from the shadow state
    function automatic logic [7:0] exp_read(input logic [15:0] addr);
        logic [ENT_W-1:0]  e;
        logic [MEM_AW-1:0] ma;
        e  = entry_of(addr);
        ma = map_addr(addr);
        if (sub_access(addr)) begin
            return ~sub_sh[slot_of(addr)];
        end
        if (e[ENT_TYPE_LSB +: 2] == BLK_NONE) begin
            return 8'hFF;
        end
        if (mem_sh.exists(int'(ma))) begin
            return mem_sh[int'(ma)];
        end
        return preload_byte(ma);
    endfunction

    // A write changes a subslot register, a bank, RAM or nothing at all
    function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
        logic [ENT_W-1:0] e;
        e = entry_of(addr);
        if (sub_access(addr)) begin
            sub_sh[slot_of(addr)] = data;
        end else if (e[ENT_TYPE_LSB +: 2] == BLK_ASCII8 && addr[15:13] == 3'b011) begin
            bank_sh[e[ENT_CART_BIT]][addr[12:11]] = data;
        end else if (e[ENT_TYPE_LSB +: 2] == BLK_RAM && !e[ENT_RO_BIT]) begin
            mem_sh[int'(map_addr(addr))] = data;
        end
    endfunction

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic cfg_write(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] data);
        cfg_we   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        if (addr < CFG_EXPANDER) begin
            lay_sh[addr[5:0]] = data[ENT_W-1:0];
        end else if (addr == CFG_EXPANDER) begin
            mask_sh = data[3:0];
        end
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic set_entry(input int slot, input int sub, input int page,
                             input block_type_e t, input logic ro, input logic cart,
                             input logic [BASE_W-1:0] base);
        logic [CFG_DW-1:0] d;
        d = '0;
        d[ENT_TYPE_LSB +: 2]      = t;
        d[ENT_RO_BIT]             = ro;
        d[ENT_CART_BIT]           = cart;
        d[ENT_BASE_LSB +: BASE_W] = base;
        cfg_write(CFG_AW'(slot * 16 + sub * 4 + page), d);
    endtask

    // One four-phase access, starting and ending on a falling edge
    task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [7:0] wdata);
        expect_t e;
        e.we     = we;
        e.data   = exp_read(addr);
        e.wdata  = wdata;
        e.to_mem = reaches_memory(we, addr);
        e.maddr  = map_addr(addr);
        e.starts = 32'(mem_starts) + 32'(e.to_mem);
        exp_q.push_back(e);
        if (we) begin
            model_write(addr, wdata);
        end
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        while (!cpu_ack) begin
            @(negedge clk);
        end
        // Hold the request one more cycle so the checker sees both high
        @(negedge clk);
        cpu_req = 1'b0;
        while (cpu_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    always @(posedge mem_req) begin
        mem_starts = mem_starts + 1;
    end

    // cpu_req and cpu_ack are both high on exactly one rising edge per access
    always @(posedge clk) begin : compare
        expect_t e;
        if (rst_n && cpu_req && cpu_ack) begin
            e = exp_q.pop_front();
            if (!e.we) begin
                checks++;
                if (cpu_rdata !== e.data) begin
                    flag_error($sformatf("read of %h returned %h, expected %h",
                                         cpu_addr, cpu_rdata, e.data));
                end
            end
            checks++;
            if (mem_starts !== e.starts) begin
                flag_error($sformatf("access to %h: memory request count %0d, expected %0d",
                                     cpu_addr, mem_starts, e.starts));
            end
            if (e.to_mem) begin
                checks++;
                if (mem_addr !== e.maddr) begin
                    flag_error($sformatf("access to %h: mem_addr %h, expected %h",
                                         cpu_addr, mem_addr, e.maddr));
                end
                checks++;
                if (mem_we !== e.we) begin
                    flag_error($sformatf("access to %h: mem_we %b, expected %b",
                                         cpu_addr, mem_we, e.we));
                end
                if (e.we && mem_wdata !== e.wdata) begin
                    flag_error($sformatf("write to %h: mem_wdata %h, expected %h",
                                         cpu_addr, mem_wdata, e.wdata));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [15:0] addr;
        seed      = 96390;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        slot_sel  = 8'h00;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = 16'h0000;
        cpu_wdata = 8'h00;
        mask_sh   = 4'h0;
        for (int i = 0; i < 64; i++) begin
            lay_sh[i] = '0;
        end
        for (int s = 0; s < 4; s++) begin
            sub_sh[s]     = 8'h00;
            bank_sh[0][s] = 8'h00;
            bank_sh[1][s] = 8'h00;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Nothing is mapped yet, so every page reads as open bus
        checks++;
        if (cpu_ack !== 1'b0 || mem_req !== 1'b0) begin
            flag_error("cpu_ack or mem_req is not low after reset");
        end
        for (int p = 0; p < 4; p++) begin
            cpu_access(1'b0, {p[1:0], 14'h0123}, 8'h00);
        end
        end_test("reset and empty slots");

        // Slot 0 holds ROM, RAM and read-only RAM; slots 1 and 2 hold ASCII8 cartridges
        set_entry(0, 0, 0, BLK_ROM, 1'b0, 1'b0, 8'h50);
        set_entry(0, 0, 1, BLK_RAM, 1'b0, 1'b0, 8'h58);
        set_entry(0, 0, 2, BLK_RAM, 1'b0, 1'b0, 8'h5C);
        set_entry(0, 0, 3, BLK_RAM, 1'b1, 1'b0, 8'h60);
        set_entry(1, 0, 1, BLK_ASCII8, 1'b0, 1'b0, 8'h40);
        set_entry(1, 0, 2, BLK_ASCII8, 1'b0, 1'b0, 8'h40);
        set_entry(2, 0, 1, BLK_ASCII8, 1'b0, 1'b1, 8'h80);
        set_entry(2, 0, 2, BLK_ASCII8, 1'b0, 1'b1, 8'h80);
        // Slot 3 gets different blocks behind each subslot
        set_entry(3, 0, 2, BLK_RAM, 1'b0, 1'b0, 8'h10);
        set_entry(3, 0, 3, BLK_RAM, 1'b0, 1'b0, 8'h30);
        set_entry(3, 1, 2, BLK_RAM, 1'b0, 1'b0, 8'h20);
        set_entry(3, 2, 1, BLK_RAM, 1'b1, 1'b0, 8'h24);

        slot_sel = 8'hF4;
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b1, 16'h8000 + 16'(i * 517), 8'(i * 29 + 3));
        end
        for (int i = 0; i < 9; i++) begin
            cpu_access(1'b0, 16'h8000 + 16'(i * 517), 8'h00);
        end
        end_test("RAM in slot 3-0 page 2");

        cfg_write(CFG_EXPANDER, 16'h0008);
        cpu_access(1'b1, 16'hFFFF, 8'h10);
        cpu_access(1'b0, 16'hFFFF, 8'h00);
        cpu_access(1'b0, 16'h8005, 8'h00);
        cpu_access(1'b1, 16'h8005, 8'h77);
        cpu_access(1'b0, 16'h8005, 8'h00);
        // Back to subslot 0, where test 2 left its bytes
        cpu_access(1'b1, 16'hFFFF, 8'h00);
        cpu_access(1'b0, 16'h8000, 8'h00);
        cpu_access(1'b0, 16'h8005, 8'h00);
        end_test("expanded slot 3");

        slot_sel = 8'hD4;
        cpu_access(1'b1, 16'h6000, 8'h03);
        cpu_access(1'b1, 16'h6800, 8'h07);
        cpu_access(1'b1, 16'h7000, 8'h0C);
        cpu_access(1'b1, 16'h7800, 8'h14);
        for (int w = 0; w < 4; w++) begin
            cpu_access(1'b0, 16'h4155 + 16'(w * 16'h2000), 8'h00);
            cpu_access(1'b0, 16'h5FFF + 16'(w * 16'h2000), 8'h00);
        end
        end_test("ASCII8 banking");

        slot_sel = 8'h00;
        cpu_access(1'b1, 16'h0123, 8'h5A);
        cpu_access(1'b0, 16'h0123, 8'h00);
        cpu_access(1'b1, 16'hC456, 8'h5A);
        cpu_access(1'b0, 16'hC456, 8'h00);
        cpu_access(1'b1, 16'hFFFF, 8'h99);
        cpu_access(1'b0, 16'hFFFF, 8'h00);
        end_test("writes to ROM and read-only RAM");

        for (int i = 0; i < N_RANDOM; i++) begin
            slot_sel = 8'($random(seed));
            addr     = 16'($random(seed));
            // Make the subslot register show up more often than chance would
            if (($random(seed) & 15) == 0) begin
                addr = 16'hFFFF;
            end
            cpu_access(1'($random(seed)), addr, 8'($random(seed)));
        end
        end_test("random accesses");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: msx_slots.f
hdl/msx_pkg.sv
hdl/subslot_reg.sv
hdl/slot_layout_map.sv
hdl/ascii8_mapper.sv
hdl/msx_slots.sv
verif/tb_memory.sv
verif/msx_slots_tb.sv

// File: Makefile
# Verilator build and run of the MSX slot subsystem testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= msx_slots_tb
FILELIST  ?= msx_slots.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Test run failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
